// ==== src/cache_pkg.sv ====
package cache_pkg;

	// byte address split: tag | index | word offset | byte offset
	localparam int addr_w = 12;
	localparam int tag_w = 5;
	localparam int idx_w = 3;
	localparam int off_w = 2;
	localparam int byte_off_w = 2;

	localparam int word_w = 32;
	localparam int line_w = 128;
	localparam int words_per_line = line_w / word_w;

	localparam int num_lines = 8;

	// backing memory is addressed by line, bits 11..4
	localparam int mem_addr_w = tag_w + idx_w;
	localparam int mem_lines = 256;

	// cycles from req seen high to ack high
	localparam int mem_latency = 4;
	localparam int lat_w = $clog2(mem_latency + 1);

	typedef logic [word_w-1:0] word_t;
	// word 0 sits in the top bits of the line
	typedef logic [0:words_per_line-1][word_w-1:0] line_t;
	typedef logic [tag_w-1:0] tag_t;
	typedef logic [idx_w-1:0] idx_t;
	typedef logic [off_w-1:0] off_t;

	typedef enum logic [2:0] {
		idle     = 3'd0,
		fill_req = 3'd1,
		fill_rel = 3'd2,
		wb_req   = 3'd3,
		wb_rel   = 3'd4,
		done     = 3'd5
	} ctrl_state_t;

endpackage

// ==== src/line_store.sv ====
`timescale 1ns/1ps

module line_store import cache_pkg::*; (
	input  logic              CLK,
	input  logic              rst_n,
	input  logic [addr_w-1:0] addr,
	input  logic              fill_en,
	input  line_t             fill_line,
	input  logic              merge_en,
	input  word_t             wdata,
	output logic              hit,
	output line_t             line,
	output word_t             rdata
);

	logic [num_lines-1:0] valid;
	tag_t tags [num_lines];
	line_t data [num_lines];

	tag_t tag;
	idx_t idx;
	off_t off;

	// address decode
	assign tag = addr[addr_w-1 -: tag_w];
	assign idx = addr[byte_off_w + off_w +: idx_w];
	assign off = addr[byte_off_w +: off_w];

	// lookup is purely combinational so a read hit answers this cycle
	assign line = data[idx];
	assign hit = valid[idx] && (tags[idx] == tag);
	assign rdata = line[off];

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (fill_en) begin
			valid[idx] <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (fill_en) begin
			tags[idx] <= tag;
			data[idx] <= fill_line;
		end else if (merge_en) begin
			// one word only, neighbours untouched
			data[idx][off] <= wdata;
		end
	end

endmodule

// ==== src/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  cs_n,
	input  logic                  wen,
	input  logic [addr_w-1:0]     addr,
	input  word_t                 wdata,
	input  logic                  hit,
	input  line_t                 line,
	input  logic                  mem_ack,
	input  line_t                 mem_rdata,
	output logic                  stall,
	output logic                  fill_en,
	output line_t                 fill_line,
	output logic                  merge_en,
	output logic                  mem_req,
	output logic                  mem_we,
	output logic [mem_addr_w-1:0] mem_line_addr,
	output line_t                 mem_wdata
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	logic access;
	logic rd_hit;
	logic wr_hit;
	off_t off;

	line_t merged;
	line_t wb_line;

	assign access = !cs_n;
	// wen low means write
	assign rd_hit = access && wen && hit;
	assign wr_hit = access && !wen && hit;
	assign off = addr[byte_off_w +: off_w];

	// same word placement as the merge inside line_store
	always_comb begin
		merged = line;
		merged[off] = wdata;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			idle: begin
				if (access && !rd_hit) begin
					// a write always goes out, a miss first needs the line
					state_nxt = hit ? wb_req : fill_req;
				end
			end
			fill_req: begin
				if (mem_ack) begin
					state_nxt = fill_rel;
				end
			end
			fill_rel: begin
				if (!mem_ack) begin
					state_nxt = idle;
				end
			end
			wb_req: begin
				if (mem_ack) begin
					state_nxt = wb_rel;
				end
			end
			wb_rel: begin
				if (!mem_ack) begin
					state_nxt = done;
				end
			end
			done: begin
				state_nxt = idle;
			end
			default: begin
				state_nxt = idle;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= idle;
		end else begin
			state <= state_nxt;
		end
	end

	// line to write through, captured at the merge edge
	always_ff @(posedge CLK) begin
		if (merge_en) begin
			wb_line <= merged;
		end
	end

	always_comb begin
		case (state)
			idle:    stall = access && !rd_hit;
			done:    stall = 1'b0;
			default: stall = 1'b1;
		endcase
	end

	// fill lands on the edge where ack is seen high
	assign fill_en = (state == fill_req) && mem_ack;
	assign fill_line = mem_rdata;

	assign merge_en = (state == idle) && wr_hit;

	// requester side of the four-phase handshake
	assign mem_req = (state == fill_req) || (state == wb_req);
	assign mem_we = (state == wb_req) || (state == wb_rel);
	assign mem_line_addr = addr[addr_w-1 -: mem_addr_w];
	assign mem_wdata = wb_line;

endmodule

// ==== src/backing_mem.sv ====
`timescale 1ns/1ps

module backing_mem import cache_pkg::*; (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  mem_req,
	input  logic                  mem_we,
	input  logic [mem_addr_w-1:0] mem_line_addr,
	input  line_t                 mem_wdata,
	output logic                  mem_ack,
	output line_t                 mem_rdata
);

	line_t mem [mem_lines];

	logic [lat_w-1:0] wait_cnt;
	logic ack_rise;

	// req has been seen for mem_latency edges counting this one
	assign ack_rise = mem_req && !mem_ack && (wait_cnt == lat_w'(mem_latency - 1));

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mem_ack <= 1'b0;
			wait_cnt <= '0;
		end else if (mem_ack) begin
			// hold ack until req drops
			if (!mem_req) begin
				mem_ack <= 1'b0;
			end
		end else if (ack_rise) begin
			mem_ack <= 1'b1;
			wait_cnt <= '0;
		end else if (mem_req) begin
			wait_cnt <= wait_cnt + 1'b1;
		end else begin
			wait_cnt <= '0;
		end
	end

	// access happens once per request, on the ack rising edge
	always_ff @(posedge CLK) begin
		if (ack_rise) begin
			if (mem_we) begin
				mem[mem_line_addr] <= mem_wdata;
			end else begin
				mem_rdata <= mem[mem_line_addr];
			end
		end
	end

endmodule

// ==== src/cache_top.sv ====
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              cs_n,
	input  logic              wen,
	input  logic [addr_w-1:0] addr,
	input  word_t             wdata,
	output word_t             rdata,
	output logic              stall
);

	// controller to line store
	logic hit;
	line_t line;
	logic fill_en;
	line_t fill_line;
	logic merge_en;

	// controller to backing memory
	logic mem_req;
	logic mem_we;
	logic [mem_addr_w-1:0] mem_line_addr;
	line_t mem_wdata;
	logic mem_ack;
	line_t mem_rdata;

	cache_ctrl ctrl_i (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.cs_n          (cs_n),
		.wen           (wen),
		.addr          (addr),
		.wdata         (wdata),
		.hit           (hit),
		.line          (line),
		.mem_ack       (mem_ack),
		.mem_rdata     (mem_rdata),
		.stall         (stall),
		.fill_en       (fill_en),
		.fill_line     (fill_line),
		.merge_en      (merge_en),
		.mem_req       (mem_req),
		.mem_we        (mem_we),
		.mem_line_addr (mem_line_addr),
		.mem_wdata     (mem_wdata)
	);

	line_store store_i (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.addr      (addr),
		.fill_en   (fill_en),
		.fill_line (fill_line),
		.merge_en  (merge_en),
		.wdata     (wdata),
		.hit       (hit),
		.line      (line),
		.rdata     (rdata)
	);

	backing_mem mem_i (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.mem_req       (mem_req),
		.mem_we        (mem_we),
		.mem_line_addr (mem_line_addr),
		.mem_wdata     (mem_wdata),
		.mem_ack       (mem_ack),
		.mem_rdata     (mem_rdata)
	);

endmodule

// ==== test/cache_checker.sv ====
`timescale 1ns/1ps

module cache_checker import cache_pkg::*; (
	input logic        CLK,
	input logic        rst_n,
	input logic        cs_n,
	input logic        stall,
	input logic        merge_en,
	input logic        mem_req,
	input logic        mem_ack,
	input ctrl_state_t state
);

	// req drops only after ack has answered
	req_release: assert property (@(posedge CLK) disable iff (!rst_n)
		$fell(mem_req) |-> $past(mem_ack))
		else $error("mem_req fell while mem_ack was still low");

	// new request only once the previous ack is gone
	req_start: assert property (@(posedge CLK) disable iff (!rst_n)
		$rose(mem_req) |-> !mem_ack)
		else $error("mem_req rose while mem_ack was still high");

	// first cycle out of reset with no access
	quiet_after_reset: assert property (@(posedge CLK)
		($rose(rst_n) && cs_n) |-> !stall)
		else $error("stall high in the first cycle after reset");

	// merge only from idle, once the memory has released ack
	merge_in_idle: assert property (@(posedge CLK) disable iff (!rst_n)
		merge_en |-> (state == idle) && !mem_ack)
		else $error("merge_en outside idle or while mem_ack was still high");

endmodule

bind cache_ctrl cache_checker chk_i (
	.CLK      (CLK),
	.rst_n    (rst_n),
	.cs_n     (cs_n),
	.stall    (stall),
	.merge_en (merge_en),
	.mem_req  (mem_req),
	.mem_ack  (mem_ack),
	.state    (state)
);

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

	localparam int half_period = 2;
	localparam int rst_cycles = 4;
	localparam int quiet_cycles = 4;
	localparam int num_fixed = 17;
	localparam int num_rand = 20;
	localparam int num_entries = num_fixed + num_rand;
	// worst case is a write miss: fill plus write-through
	localparam int cycles_per_entry = 4 * mem_latency + 8;
	localparam int cycle_limit = num_entries * cycles_per_entry + rst_cycles + quiet_cycles + 8;

	logic CLK;
	logic rst_n;
	logic cs_n;
	logic wen;
	logic [addr_w-1:0] addr;
	word_t wdata;
	word_t rdata;
	logic stall;

	// stimulus table: write flag, byte address, write data, hit expected
	logic tbl_wr [num_entries];
	logic [addr_w-1:0] tbl_addr [num_entries];
	word_t tbl_data [num_entries];
	logic tbl_hit [num_entries];
	int tbl_len;

	// reference model keyed by word address
	word_t ref_mem [int];

	integer seed;
	int value_errors;
	int other_errors;
	int cycle_cnt = 0;

	cache_top dut_i (
		.CLK   (CLK),
		.rst_n (rst_n),
		.cs_n  (cs_n),
		.wen   (wen),
		.addr  (addr),
		.wdata (wdata),
		.rdata (rdata),
		.stall (stall)
	);

	initial CLK = 1'b0;
	always #half_period CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, an access never finished", cycle_cnt);
			$display("errors: %0d value mismatches, %0d other failures",
				value_errors, other_errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic add_entry(input logic is_wr, input logic [addr_w-1:0] a,
		input word_t d, input logic expect_hit);
		tbl_wr[tbl_len] = is_wr;
		tbl_addr[tbl_len] = a;
		tbl_data[tbl_len] = d;
		tbl_hit[tbl_len] = expect_hit;
		tbl_len++;
	endtask

	task automatic build_table();
		logic [addr_w-1:0] written [$];
		logic [31:0] r;
		logic [addr_w-1:0] a;
		int pick;
		tbl_len = 0;
		// cold write, then read back
		add_entry(1'b1, 12'h010, 32'h1111_0010, 1'b0);
		add_entry(1'b0, 12'h010, '0, 1'b1);
		// same index, two tags
		add_entry(1'b1, 12'h024, 32'h2222_0024, 1'b0);
		add_entry(1'b1, 12'h0a4, 32'h3333_00a4, 1'b0);
		add_entry(1'b0, 12'h024, '0, 1'b0);
		add_entry(1'b0, 12'h0a4, '0, 1'b0);
		// all four words of one line
		add_entry(1'b1, 12'h140, 32'hd000_0140, 1'b0);
		add_entry(1'b1, 12'h144, 32'hd111_0144, 1'b0);
		add_entry(1'b1, 12'h148, 32'hd222_0148, 1'b0);
		add_entry(1'b1, 12'h14c, 32'hd333_014c, 1'b0);
		add_entry(1'b0, 12'h140, '0, 1'b1);
		add_entry(1'b0, 12'h144, '0, 1'b1);
		add_entry(1'b0, 12'h148, '0, 1'b1);
		add_entry(1'b0, 12'h14c, '0, 1'b1);
		// resident lines again
		add_entry(1'b0, 12'h14c, '0, 1'b1);
		add_entry(1'b0, 12'h140, '0, 1'b1);
		add_entry(1'b0, 12'h010, '0, 1'b1);
		// random mix over two tags and four indices
		for (int i = 0; i < num_rand; i++) begin
			r = $random(seed);
			if (written.size() == 0 || r[0]) begin
				a = {4'b1100, r[1], 1'b0, r[3:2], r[5:4], 2'b00};
				written.push_back(a);
				add_entry(1'b1, a, $random(seed), 1'b0);
			end else begin
				pick = $unsigned($random(seed)) % written.size();
				add_entry(1'b0, written[pick], '0, 1'b0);
			end
		end
	endtask

	task automatic run_access(input int i);
		int waits;
		int key;
		waits = 0;
		key = int'(tbl_addr[i][addr_w-1:2]);
		@(negedge CLK);
		cs_n = 1'b0;
		wen = !tbl_wr[i];
		addr = tbl_addr[i];
		wdata = tbl_wr[i] ? tbl_data[i] : '0;
		#(half_period / 2);
		while (stall) begin
			@(negedge CLK);
			#(half_period / 2);
			waits++;
		end
		// stall low here, so the coming edge completes the access
		if (!tbl_wr[i]) begin
			if (ref_mem.exists(key)) begin
				check("rdata", rdata, ref_mem[key]);
			end else begin
				other_errors++;
				$display("read of address %h that was never written", tbl_addr[i]);
			end
			if (tbl_hit[i]) begin
				check("read hit stall cycles", word_t'(waits), '0);
			end
		end
		@(posedge CLK);
		if (tbl_wr[i]) begin
			ref_mem[key] = tbl_data[i];
		end
	endtask

	initial begin
		seed = 32'hb5d139c0;
		value_errors = 0;
		other_errors = 0;
		rst_n = 1'b0;
		cs_n = 1'b1;
		wen = 1'b1;
		addr = '0;
		wdata = '0;
		build_table();
		repeat (rst_cycles) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;
		// no access yet
		repeat (quiet_cycles) begin
			#(half_period / 2);
			check("stall", word_t'(stall), '0);
			@(negedge CLK);
		end
		for (int i = 0; i < tbl_len; i++) begin
			run_access(i);
		end
		@(negedge CLK);
		cs_n = 1'b1;
		repeat (2) @(posedge CLK);
		$display("errors: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
src/cache_pkg.sv
src/line_store.sv
src/cache_ctrl.sv
src/backing_mem.sv
src/cache_top.sv
test/cache_checker.sv
test/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

FAIL_MSG="TEST FAILED"
LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 --top-module cache_tb \
	-Mdir "$OBJ" -o cache_sim -f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/cache_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

# a failed assertion or a crash counts as a failed run
if [ $status -ne 0 ] || grep -q "%Error" "$LOG"; then
	echo "simulation stopped with errors (status $status)" | tee -a "$LOG"
	echo "$FAIL_MSG" | tee -a "$LOG"
fi

if grep -q "$FAIL_MSG" "$LOG"; then
	echo "run failed, see $LOG"
	exit 1
fi

echo "run passed, see $LOG"
exit 0
